/* Makefile */
TOP = mem_subsystem_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -f project.f --top-module mem_subsystem

clean:
	rm -rf obj_dir

/* include/axi_defines.svh */
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// Bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_STRB_W 8
`define AXI_ID_W 4

// Power of two SRAM depth in 64-bit words
`define SRAM_WORDS 1024

`endif

/* project.f */
+incdir+include
verilog/axi_pkg.sv
verilog/axi_arbiter.sv
verilog/axi_sram.sv
verilog/mem_subsystem.sv
verification/mem_subsystem_tb.sv

/* verification/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`include "axi_defines.svh"

module mem_subsystem_tb;

  localparam int SEED        = 57;
  localparam int WRITE_TESTS = 40;
  localparam int IFU_TESTS   = 30;
  localparam int RACE_TESTS  = 8;
  localparam int MIXED_TESTS = 10;
  // Several times the cycles that all bursts take together
  localparam int TIMEOUT_CYCLES = 20000;

  logic               clock;
  logic               reset;
  logic               ifu_ar_valid;
  axi_pkg::axi_addr_t ifu_ar;
  logic               ifu_ar_ready;
  logic               ifu_r_valid;
  axi_pkg::axi_r_t    ifu_r;
  logic               ifu_r_ready;
  logic               exu_ar_valid;
  axi_pkg::axi_addr_t exu_ar;
  logic               exu_ar_ready;
  logic               exu_r_valid;
  axi_pkg::axi_r_t    exu_r;
  logic               exu_r_ready;
  logic               exu_aw_valid;
  axi_pkg::axi_addr_t exu_aw;
  logic               exu_aw_ready;
  logic               exu_w_valid;
  axi_pkg::axi_w_t    exu_w;
  logic               exu_w_ready;
  logic               exu_b_valid;
  axi_pkg::axi_b_t    exu_b;
  logic               exu_b_ready;

  logic [`AXI_DATA_W-1:0] shadow [`SRAM_WORDS];
  logic                   slow_rready;
  int                     cycles = 0;
  // Index 0 is ifu and index 1 is exu
  int                     first_r_cycle [2];
  int                     last_r_cycle [2];
  int                     b_cycle;

  mem_subsystem u_mem_subsystem (
    .clock          (clock),
    .reset          (reset),
    .ifu_ar_valid_i (ifu_ar_valid),
    .ifu_ar_i       (ifu_ar),
    .ifu_ar_ready_o (ifu_ar_ready),
    .ifu_r_valid_o  (ifu_r_valid),
    .ifu_r_o        (ifu_r),
    .ifu_r_ready_i  (ifu_r_ready),
    .exu_ar_valid_i (exu_ar_valid),
    .exu_ar_i       (exu_ar),
    .exu_ar_ready_o (exu_ar_ready),
    .exu_r_valid_o  (exu_r_valid),
    .exu_r_o        (exu_r),
    .exu_r_ready_i  (exu_r_ready),
    .exu_aw_valid_i (exu_aw_valid),
    .exu_aw_i       (exu_aw),
    .exu_aw_ready_o (exu_aw_ready),
    .exu_w_valid_i  (exu_w_valid),
    .exu_w_i        (exu_w),
    .exu_w_ready_o  (exu_w_ready),
    .exu_b_valid_o  (exu_b_valid),
    .exu_b_o        (exu_b),
    .exu_b_ready_i  (exu_b_ready)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("TEST FAIL");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_fault(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic check_r(input string name, input axi_pkg::axi_r_t exp,
                         input axi_pkg::axi_r_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_b(input string name, input axi_pkg::axi_b_t exp,
                         input axi_pkg::axi_b_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_idle(input string name, input logic [6:0] exp, input logic [6:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [63:0] fill_word(input int word);
    return {32'hC0DE_0000 ^ 32'(word), 32'(word) * 32'h9E37_79B9};
  endfunction

  function automatic axi_pkg::axi_addr_t make_req(input int word, input int len,
                                                  input axi_pkg::burst_e burst);
    axi_pkg::axi_addr_t a;
    a.id    = 4'($urandom);
    a.addr  = 32'(word) << 3;
    a.len   = 8'(len);
    a.size  = 3'd3;
    a.burst = burst;
    return a;
  endfunction

  // Random in-range INCR or FIXED burst
  function automatic axi_pkg::axi_addr_t rand_req();
    int              len;
    axi_pkg::burst_e burst;
    len   = int'($urandom_range(0, 15));
    burst = ($urandom_range(0, 1) == 0) ? axi_pkg::FIXED : axi_pkg::INCR;
    return make_req(int'($urandom_range(0, `SRAM_WORDS - 1 - len)), len, burst);
  endfunction

  function automatic bit burst_ok(input axi_pkg::burst_e burst);
    return burst == axi_pkg::INCR || burst == axi_pkg::FIXED;
  endfunction

  function automatic int beat_word(input axi_pkg::axi_addr_t a, input int beat);
    return int'(a.addr >> 3) + ((a.burst == axi_pkg::INCR) ? beat : 0);
  endfunction

  // Reference beat from the shadow memory
  function automatic axi_pkg::axi_r_t expect_r(input axi_pkg::axi_addr_t ar, input int beat);
    axi_pkg::axi_r_t r;
    int              word;
    word   = beat_word(ar, beat);
    r.id   = ar.id;
    r.last = (beat == int'(ar.len));
    if (word >= `SRAM_WORDS || !burst_ok(ar.burst)) begin
      r.data = '0;
      r.resp = axi_pkg::SLVERR;
    end else begin
      r.data = shadow[word];
      r.resp = axi_pkg::OKAY;
    end
    return r;
  endfunction

  task automatic drive_ar(input bit is_ifu, input logic valid, input axi_pkg::axi_addr_t ar);
    if (is_ifu) begin
      ifu_ar_valid = valid;
      ifu_ar       = ar;
    end else begin
      exu_ar_valid = valid;
      exu_ar       = ar;
    end
  endtask

  task automatic drive_r_ready(input bit is_ifu, input logic rdy);
    if (is_ifu) begin
      ifu_r_ready = rdy;
    end else begin
      exu_r_ready = rdy;
    end
  endtask

  task automatic read_burst(input bit is_ifu, input axi_pkg::axi_addr_t ar, input string name);
    axi_pkg::axi_r_t act;
    logic            rdy;
    logic            rvalid;
    logic            other;
    int              beat;
    int              side;
    side = is_ifu ? 0 : 1;
    first_r_cycle[side] = -1;
    @(negedge clock);
    drive_ar(is_ifu, 1'b1, ar);
    #10;
    while (!(is_ifu ? ifu_ar_ready : exu_ar_ready)) begin
      @(negedge clock);
      #10;
    end
    @(negedge clock);
    drive_ar(is_ifu, 1'b0, '0);
    beat = 0;
    while (beat <= int'(ar.len)) begin
      rdy = !slow_rready || ($urandom_range(0, 3) != 0);
      drive_r_ready(is_ifu, rdy);
      #10;
      rvalid = is_ifu ? ifu_r_valid : exu_r_valid;
      other  = is_ifu ? exu_r_valid : ifu_r_valid;
      act    = is_ifu ? ifu_r : exu_r;
      if (other) begin
        report_fault({"Test ", name, " saw R valid on the master that has no grant"});
      end
      if (rvalid && first_r_cycle[side] < 0) begin
        first_r_cycle[side] = cycles;
      end
      if (rvalid && rdy) begin
        check_r(name, expect_r(ar, beat), act);
        last_r_cycle[side] = cycles;
        beat++;
      end
      @(negedge clock);
    end
    drive_r_ready(is_ifu, 1'b0);
  endtask

  task automatic write_burst(input axi_pkg::axi_addr_t aw, input bit fill, input string name);
    axi_pkg::axi_w_t w;
    axi_pkg::axi_b_t exp;
    bit              err;
    int              word;
    err = !burst_ok(aw.burst);
    for (int beat = 0; beat <= int'(aw.len); beat++) begin
      if (beat_word(aw, beat) >= `SRAM_WORDS) begin
        err = 1'b1;
      end
    end
    @(negedge clock);
    exu_aw_valid = 1'b1;
    exu_aw       = aw;
    #10;
    while (!exu_aw_ready) begin
      @(negedge clock);
      #10;
    end
    @(negedge clock);
    exu_aw_valid = 1'b0;
    exu_aw       = '0;
    for (int beat = 0; beat <= int'(aw.len); beat++) begin
      word        = beat_word(aw, beat);
      w.data      = fill ? fill_word(word) : {$urandom, $urandom};
      w.strb      = fill ? 8'hff : 8'($urandom);
      w.last      = (beat == int'(aw.len));
      exu_w_valid = 1'b1;
      exu_w       = w;
      #10;
      while (!exu_w_ready) begin
        @(negedge clock);
        #10;
      end
      // A failing burst leaves the memory as it was
      if (!err) begin
        for (int i = 0; i < `AXI_STRB_W; i++) begin
          if (w.strb[i]) begin
            shadow[word][8*i +: 8] = w.data[8*i +: 8];
          end
        end
      end
      @(negedge clock);
    end
    exu_w_valid = 1'b0;
    exu_w       = '0;
    exu_b_ready = 1'b1;
    #10;
    while (!exu_b_valid) begin
      @(negedge clock);
      #10;
    end
    exp.id   = aw.id;
    exp.resp = err ? axi_pkg::SLVERR : axi_pkg::OKAY;
    check_b(name, exp, exu_b);
    b_cycle = cycles;
    @(negedge clock);
    exu_b_ready = 1'b0;
  endtask

  initial begin
    axi_pkg::axi_addr_t wr;
    axi_pkg::axi_addr_t rd;
    void'($urandom(SEED));
    reset        = 1'b0;
    slow_rready  = 1'b0;
    ifu_ar_valid = 1'b0;
    ifu_ar       = '0;
    ifu_r_ready  = 1'b0;
    exu_ar_valid = 1'b0;
    exu_ar       = '0;
    exu_r_ready  = 1'b0;
    exu_aw_valid = 1'b0;
    exu_aw       = '0;
    exu_w_valid  = 1'b0;
    exu_w        = '0;
    exu_b_ready  = 1'b0;
    repeat (5) @(negedge clock);
    reset = 1'b1;

    repeat (3) begin
      @(negedge clock);
      #10;
      check_idle("reset_idle", 7'd0, {ifu_ar_ready, ifu_r_valid, exu_ar_ready, exu_r_valid,
                                      exu_aw_ready, exu_w_ready, exu_b_valid});
    end

    // Known contents everywhere before any read
    for (int b = 0; b < `SRAM_WORDS / 16; b++) begin
      write_burst(make_req(b * 16, 15, axi_pkg::INCR), 1'b1, "fill");
    end

    repeat (WRITE_TESTS) begin
      wr = rand_req();
      write_burst(wr, 1'b0, "exu_write");
      rd    = wr;
      rd.id = 4'($urandom);
      read_burst(1'b0, rd, "exu_read_back");
    end

    repeat (IFU_TESTS) begin
      read_burst(1'b1, rand_req(), "ifu_read");
    end

    repeat (RACE_TESTS) begin
      wr = rand_req();
      rd = rand_req();
      fork
        read_burst(1'b1, rand_req(), "race_ifu_read");
        read_burst(1'b0, rd, "race_exu_read");
        write_burst(wr, 1'b0, "race_exu_write");
      join
      if (first_r_cycle[1] <= last_r_cycle[0]) begin
        report_fault("Test race: an exu R beat came before the ifu burst ended");
      end
      if (b_cycle <= last_r_cycle[1]) begin
        report_fault("Test race: the exu write was served before the exu read");
      end
    end

    slow_rready = 1'b1;
    fork
      begin
        repeat (2 * MIXED_TESTS) begin
          read_burst(1'b1, rand_req(), "slow_ifu_read");
        end
      end
      begin
        repeat (MIXED_TESTS) begin
          wr = rand_req();
          write_burst(wr, 1'b0, "slow_exu_write");
          read_burst(1'b0, wr, "slow_exu_read");
        end
      end
    join
    slow_rready = 1'b0;

    // Error responses
    rd = make_req(`SRAM_WORDS + int'($urandom_range(0, 64)), 3, axi_pkg::INCR);
    read_burst(1'b0, rd, "read_past_end");
    read_burst(1'b1, make_req(`SRAM_WORDS - 2, 5, axi_pkg::INCR), "read_across_end");
    write_burst(make_req(`SRAM_WORDS - 3, 7, axi_pkg::INCR), 1'b0, "write_across_end");
    read_burst(1'b0, make_req(`SRAM_WORDS - 8, 7, axi_pkg::INCR), "after_write_across_end");
    write_burst(make_req(`SRAM_WORDS + 10, 0, axi_pkg::FIXED), 1'b0, "write_past_end");
    write_burst(make_req(100, 3, axi_pkg::WRAP), 1'b0, "write_wrap");
    read_burst(1'b1, make_req(100, 3, axi_pkg::INCR), "after_write_wrap");

    $display("TEST PASS");
    $finish;
  end

endmodule

/* verilog/axi_arbiter.sv */
`timescale 1ns/1ps

module axi_arbiter (
  input  logic                clock,
  input  logic                reset,
  // ifu side
  input  logic                ifu_ar_valid_i,
  input  axi_pkg::axi_addr_t  ifu_ar_i,
  output logic                ifu_ar_ready_o,
  output logic                ifu_r_valid_o,
  output axi_pkg::axi_r_t     ifu_r_o,
  input  logic                ifu_r_ready_i,
  // exu side
  input  logic                exu_ar_valid_i,
  input  axi_pkg::axi_addr_t  exu_ar_i,
  output logic                exu_ar_ready_o,
  output logic                exu_r_valid_o,
  output axi_pkg::axi_r_t     exu_r_o,
  input  logic                exu_r_ready_i,
  input  logic                exu_aw_valid_i,
  input  axi_pkg::axi_addr_t  exu_aw_i,
  output logic                exu_aw_ready_o,
  input  logic                exu_w_valid_i,
  input  axi_pkg::axi_w_t     exu_w_i,
  output logic                exu_w_ready_o,
  output logic                exu_b_valid_o,
  output axi_pkg::axi_b_t     exu_b_o,
  input  logic                exu_b_ready_i,
  // mem side
  output logic                mem_ar_valid_o,
  output axi_pkg::axi_addr_t  mem_ar_o,
  input  logic                mem_ar_ready_i,
  input  logic                mem_r_valid_i,
  input  axi_pkg::axi_r_t     mem_r_i,
  output logic                mem_r_ready_o,
  output logic                mem_aw_valid_o,
  output axi_pkg::axi_addr_t  mem_aw_o,
  input  logic                mem_aw_ready_i,
  output logic                mem_w_valid_o,
  output axi_pkg::axi_w_t     mem_w_o,
  input  logic                mem_w_ready_i,
  input  logic                mem_b_valid_i,
  input  axi_pkg::axi_b_t     mem_b_i,
  output logic                mem_b_ready_o
);

  axi_pkg::arb_state_e state_q;
  axi_pkg::arb_state_e state_d;
  logic                r_done;
  logic                b_done;

  // Transaction ends on the last read beat or the write response
  assign r_done = mem_r_valid_i && mem_r_ready_o && mem_r_i.last;
  assign b_done = mem_b_valid_i && mem_b_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      axi_pkg::IDLE: begin
        // Fixed priority
        if (ifu_ar_valid_i) begin
          state_d = axi_pkg::IFU_READ;
        end else if (exu_ar_valid_i) begin
          state_d = axi_pkg::EXU_READ;
        end else if (exu_aw_valid_i) begin
          state_d = axi_pkg::EXU_WRITE;
        end
      end
      axi_pkg::IFU_READ,
      axi_pkg::EXU_READ: begin
        if (r_done) begin
          state_d = axi_pkg::IDLE;
        end
      end
      axi_pkg::EXU_WRITE: begin
        if (b_done) begin
          state_d = axi_pkg::IDLE;
        end
      end
      default: state_d = axi_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state_q <= axi_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Steer the granted master and hold all other outputs at zero
  always_comb begin
    ifu_ar_ready_o = 1'b0;
    ifu_r_valid_o  = 1'b0;
    ifu_r_o        = '0;
    exu_ar_ready_o = 1'b0;
    exu_r_valid_o  = 1'b0;
    exu_r_o        = '0;
    exu_aw_ready_o = 1'b0;
    exu_w_ready_o  = 1'b0;
    exu_b_valid_o  = 1'b0;
    exu_b_o        = '0;
    mem_ar_valid_o = 1'b0;
    mem_ar_o       = '0;
    mem_r_ready_o  = 1'b0;
    mem_aw_valid_o = 1'b0;
    mem_aw_o       = '0;
    mem_w_valid_o  = 1'b0;
    mem_w_o        = '0;
    mem_b_ready_o  = 1'b0;
    case (state_q)
      axi_pkg::IFU_READ: begin
        mem_ar_valid_o = ifu_ar_valid_i;
        mem_ar_o       = ifu_ar_i;
        ifu_ar_ready_o = mem_ar_ready_i;
        ifu_r_valid_o  = mem_r_valid_i;
        ifu_r_o        = mem_r_i;
        mem_r_ready_o  = ifu_r_ready_i;
      end
      axi_pkg::EXU_READ: begin
        mem_ar_valid_o = exu_ar_valid_i;
        mem_ar_o       = exu_ar_i;
        exu_ar_ready_o = mem_ar_ready_i;
        exu_r_valid_o  = mem_r_valid_i;
        exu_r_o        = mem_r_i;
        mem_r_ready_o  = exu_r_ready_i;
      end
      axi_pkg::EXU_WRITE: begin
        mem_aw_valid_o = exu_aw_valid_i;
        mem_aw_o       = exu_aw_i;
        exu_aw_ready_o = mem_aw_ready_i;
        mem_w_valid_o  = exu_w_valid_i;
        mem_w_o        = exu_w_i;
        exu_w_ready_o  = mem_w_ready_i;
        exu_b_valid_o  = mem_b_valid_i;
        exu_b_o        = mem_b_i;
        mem_b_ready_o  = exu_b_ready_i;
      end
      default: begin
      end
    endcase
  end

  // The memory answers only the transaction that holds the grant
  a_r_under_read_grant: assert property (@(posedge clock) disable iff (!reset)
    mem_r_valid_i |-> (state_q == axi_pkg::IFU_READ || state_q == axi_pkg::EXU_READ));

  a_b_under_write_grant: assert property (@(posedge clock) disable iff (!reset)
    mem_b_valid_i |-> (state_q == axi_pkg::EXU_WRITE));

endmodule

/* verilog/axi_pkg.sv */
`include "axi_defines.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    IDLE,
    IFU_READ,
    EXU_READ,
    EXU_WRITE
  } arb_state_e;

  // Shared by AR and AW
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    burst_e                 burst;
  } axi_addr_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    resp_e                resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    resp_e                  resp;
    logic                   last;
  } axi_r_t;

endpackage

/* verilog/axi_sram.sv */
`timescale 1ns/1ps
`include "axi_defines.svh"

module axi_sram (
  input  logic                clock,
  input  logic                reset,
  input  logic                ar_valid_i,
  input  axi_pkg::axi_addr_t  ar_i,
  output logic                ar_ready_o,
  output logic                r_valid_o,
  output axi_pkg::axi_r_t     r_o,
  input  logic                r_ready_i,
  input  logic                aw_valid_i,
  input  axi_pkg::axi_addr_t  aw_i,
  output logic                aw_ready_o,
  input  logic                w_valid_i,
  input  axi_pkg::axi_w_t     w_i,
  output logic                w_ready_o,
  output logic                b_valid_o,
  output axi_pkg::axi_b_t     b_o,
  input  logic                b_ready_i
);

  localparam int WORD_AW = `AXI_ADDR_W - 3;
  localparam int IDX_W   = $clog2(`SRAM_WORDS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WRITE,
    S_RESP
  } sram_state_e;

  sram_state_e             state_q;
  logic [`AXI_DATA_W-1:0]  mem_q [`SRAM_WORDS];
  logic [`AXI_ID_W-1:0]    id_q;
  logic [WORD_AW-1:0]      addr_q;
  logic [7:0]              cnt_q;
  axi_pkg::burst_e         burst_q;
  logic                    err_q;

  logic                    ar_fire;
  logic                    aw_fire;
  logic                    r_fire;
  logic                    w_fire;
  logic                    rd_err;
  logic [WORD_AW:0]        aw_end;
  logic                    aw_err;

  // AR wins if both arrive together
  assign ar_ready_o = (state_q == S_IDLE);
  assign aw_ready_o = (state_q == S_IDLE) && !ar_valid_i;
  assign w_ready_o  = (state_q == S_WRITE);
  assign r_valid_o  = (state_q == S_READ);
  assign b_valid_o  = (state_q == S_RESP);

  assign ar_fire = ar_valid_i && ar_ready_o;
  assign aw_fire = aw_valid_i && aw_ready_o;
  assign r_fire  = r_valid_o && r_ready_i;
  assign w_fire  = w_valid_i && w_ready_o;

  // Last word touched by the write burst decides SLVERR up front
  assign aw_end = {1'b0, aw_i.addr[`AXI_ADDR_W-1:3]}
                + ((aw_i.burst == axi_pkg::INCR) ? (WORD_AW + 1)'(aw_i.len) : '0);
  assign aw_err = !(aw_i.burst == axi_pkg::INCR || aw_i.burst == axi_pkg::FIXED)
                || (aw_end >= (WORD_AW + 1)'(`SRAM_WORDS));

  assign rd_err = (addr_q >= WORD_AW'(`SRAM_WORDS))
                || !(burst_q == axi_pkg::INCR || burst_q == axi_pkg::FIXED);

  always_comb begin
    r_o.id   = id_q;
    r_o.data = rd_err ? '0 : mem_q[addr_q[IDX_W-1:0]];
    r_o.resp = rd_err ? axi_pkg::SLVERR : axi_pkg::OKAY;
    r_o.last = (cnt_q == 8'd0);
    b_o.id   = id_q;
    b_o.resp = err_q ? axi_pkg::SLVERR : axi_pkg::OKAY;
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (ar_fire) begin
            state_q <= S_READ;
          end else if (aw_fire) begin
            state_q <= S_WRITE;
          end
        end
        S_READ: begin
          if (r_fire && (cnt_q == 8'd0)) begin
            state_q <= S_IDLE;
          end
        end
        S_WRITE: begin
          if (w_fire && w_i.last) begin
            state_q <= S_RESP;
          end
        end
        S_RESP: begin
          if (b_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Burst bookkeeping
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      id_q    <= ar_i.id;
      addr_q  <= ar_i.addr[`AXI_ADDR_W-1:3];
      cnt_q   <= ar_i.len;
      burst_q <= ar_i.burst;
    end else if (aw_fire) begin
      id_q    <= aw_i.id;
      addr_q  <= aw_i.addr[`AXI_ADDR_W-1:3];
      cnt_q   <= aw_i.len;
      burst_q <= aw_i.burst;
      err_q   <= aw_err;
    end else if (r_fire || w_fire) begin
      cnt_q <= cnt_q - 8'd1;
      if (burst_q == axi_pkg::INCR) begin
        addr_q <= addr_q + WORD_AW'(1);
      end
    end
  end

  // Strobed write that drops the whole burst on error
  always_ff @(posedge clock) begin
    if (w_fire && !err_q) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (w_i.strb[i]) begin
          mem_q[addr_q[IDX_W-1:0]][8*i +: 8] <= w_i.data[8*i +: 8];
        end
      end
    end
  end

  a_r_hold: assert property (@(posedge clock) disable iff (!reset)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_o)));

  // W last closes the burst exactly at beat len
  a_w_last_on_count: assert property (@(posedge clock) disable iff (!reset)
    w_fire |-> (w_i.last == (cnt_q == 8'd0)));

endmodule

/* verilog/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                clock,
  input  logic                reset,
  input  logic                ifu_ar_valid_i,
  input  axi_pkg::axi_addr_t  ifu_ar_i,
  output logic                ifu_ar_ready_o,
  output logic                ifu_r_valid_o,
  output axi_pkg::axi_r_t     ifu_r_o,
  input  logic                ifu_r_ready_i,
  input  logic                exu_ar_valid_i,
  input  axi_pkg::axi_addr_t  exu_ar_i,
  output logic                exu_ar_ready_o,
  output logic                exu_r_valid_o,
  output axi_pkg::axi_r_t     exu_r_o,
  input  logic                exu_r_ready_i,
  input  logic                exu_aw_valid_i,
  input  axi_pkg::axi_addr_t  exu_aw_i,
  output logic                exu_aw_ready_o,
  input  logic                exu_w_valid_i,
  input  axi_pkg::axi_w_t     exu_w_i,
  output logic                exu_w_ready_o,
  output logic                exu_b_valid_o,
  output axi_pkg::axi_b_t     exu_b_o,
  input  logic                exu_b_ready_i
);

  // Arbiter to SRAM
  logic                mem_ar_valid;
  axi_pkg::axi_addr_t  mem_ar;
  logic                mem_ar_ready;
  logic                mem_r_valid;
  axi_pkg::axi_r_t     mem_r;
  logic                mem_r_ready;
  logic                mem_aw_valid;
  axi_pkg::axi_addr_t  mem_aw;
  logic                mem_aw_ready;
  logic                mem_w_valid;
  axi_pkg::axi_w_t     mem_w;
  logic                mem_w_ready;
  logic                mem_b_valid;
  axi_pkg::axi_b_t     mem_b;
  logic                mem_b_ready;

  axi_arbiter u_arbiter (
    .clock          (clock),
    .reset          (reset),
    .ifu_ar_valid_i (ifu_ar_valid_i),
    .ifu_ar_i       (ifu_ar_i),
    .ifu_ar_ready_o (ifu_ar_ready_o),
    .ifu_r_valid_o  (ifu_r_valid_o),
    .ifu_r_o        (ifu_r_o),
    .ifu_r_ready_i  (ifu_r_ready_i),
    .exu_ar_valid_i (exu_ar_valid_i),
    .exu_ar_i       (exu_ar_i),
    .exu_ar_ready_o (exu_ar_ready_o),
    .exu_r_valid_o  (exu_r_valid_o),
    .exu_r_o        (exu_r_o),
    .exu_r_ready_i  (exu_r_ready_i),
    .exu_aw_valid_i (exu_aw_valid_i),
    .exu_aw_i       (exu_aw_i),
    .exu_aw_ready_o (exu_aw_ready_o),
    .exu_w_valid_i  (exu_w_valid_i),
    .exu_w_i        (exu_w_i),
    .exu_w_ready_o  (exu_w_ready_o),
    .exu_b_valid_o  (exu_b_valid_o),
    .exu_b_o        (exu_b_o),
    .exu_b_ready_i  (exu_b_ready_i),
    .mem_ar_valid_o (mem_ar_valid),
    .mem_ar_o       (mem_ar),
    .mem_ar_ready_i (mem_ar_ready),
    .mem_r_valid_i  (mem_r_valid),
    .mem_r_i        (mem_r),
    .mem_r_ready_o  (mem_r_ready),
    .mem_aw_valid_o (mem_aw_valid),
    .mem_aw_o       (mem_aw),
    .mem_aw_ready_i (mem_aw_ready),
    .mem_w_valid_o  (mem_w_valid),
    .mem_w_o        (mem_w),
    .mem_w_ready_i  (mem_w_ready),
    .mem_b_valid_i  (mem_b_valid),
    .mem_b_i        (mem_b),
    .mem_b_ready_o  (mem_b_ready)
  );

  axi_sram u_sram (
    .clock      (clock),
    .reset      (reset),
    .ar_valid_i (mem_ar_valid),
    .ar_i       (mem_ar),
    .ar_ready_o (mem_ar_ready),
    .r_valid_o  (mem_r_valid),
    .r_o        (mem_r),
    .r_ready_i  (mem_r_ready),
    .aw_valid_i (mem_aw_valid),
    .aw_i       (mem_aw),
    .aw_ready_o (mem_aw_ready),
    .w_valid_i  (mem_w_valid),
    .w_i        (mem_w),
    .w_ready_o  (mem_w_ready),
    .b_valid_o  (mem_b_valid),
    .b_o        (mem_b),
    .b_ready_i  (mem_b_ready)
  );

endmodule
